// ==== verilog/rv_exec_pkg.sv ====
`default_nettype none

package rv_exec_pkg;

    // --------------------
    // widths and sizes
    // --------------------

    localparam int xlen = 32;

    // RV32E has x0..x15
    localparam int reg_count = 16;

    // index fields keep the full 5-bit instruction encoding
    localparam int reg_idx_bits = 5;
    localparam int csr_addr_bits = 12;

    // sequential step, also the link offset for jal/jalr
    localparam logic [xlen-1:0] pc_step = 32'd4;

    // --------------------
    // decoded control encodings
    // --------------------

    // alu function, negate and arith are separate flags
    typedef enum logic [2:0] {
        op_add  = 3'd0,
        op_sll  = 3'd1,
        op_slt  = 3'd2,
        op_sltu = 3'd3,
        op_xor  = 3'd4,
        op_sr   = 3'd5,
        op_or   = 3'd6,
        op_and  = 3'd7
    } alu_op_t;

    // alu operand pair
    typedef enum logic [1:0] {
        src_imm     = 2'd0,
        src_pc_imm  = 2'd1,
        src_rs1_rs2 = 2'd2,
        src_rs1_imm = 2'd3
    } src_sel_t;

    // how the next pc is formed
    typedef enum logic [1:0] {
        tgt_branch  = 2'd0,
        tgt_seq     = 2'd1,
        tgt_pc_imm  = 2'd2,
        tgt_rs1_imm = 2'd3
    } target_t;

    // memory access width, none means no access
    typedef enum logic [1:0] {
        size_none = 2'd0,
        size_byte = 2'd1,
        size_half = 2'd2,
        size_word = 2'd3
    } mem_size_t;

endpackage

`default_nettype wire

// ==== verilog/alu.sv ====
`default_nettype none

module alu (
    input  logic [rv_exec_pkg::xlen-1:0] a,
    input  logic [rv_exec_pkg::xlen-1:0] b,
    input  rv_exec_pkg::alu_op_t         op,
    input  logic                         negate,
    input  logic                         arith,
    input  logic                         seq_pc,
    output logic [rv_exec_pkg::xlen-1:0] result
);
    import rv_exec_pkg::*;

    logic [4:0]      shamt;
    logic [xlen-1:0] b_eff;
    logic [xlen-1:0] sum;
    logic            lt_signed;
    logic            lt_unsigned;
    logic [xlen-1:0] shift_right;

    assign shamt = b[4:0];

    // --------------------
    // adder and compares
    // --------------------

    // one adder for both add and subtract
    assign b_eff = b ^ {xlen{negate}};
    assign sum = a + b_eff + {{(xlen-1){1'b0}}, negate};

    assign lt_signed = $signed(a) < $signed(b);
    assign lt_unsigned = a < b;

    // arithmetic or logical right shift
    assign shift_right = arith ? xlen'($signed(a) >>> shamt) : (a >> shamt);

    // --------------------
    // result select
    // --------------------

    always_comb begin
        if (seq_pc) begin
            // link address, the op field is ignored
            result = a + pc_step;
        end else begin
            case (op)
                op_add:  result = sum;
                op_sll:  result = a << shamt;
                // negate flips the compare so bge/bgeu reuse it
                op_slt:  result = {{(xlen-1){1'b0}}, lt_signed ^ negate};
                op_sltu: result = {{(xlen-1){1'b0}}, lt_unsigned ^ negate};
                op_xor:  result = a ^ b;
                op_sr:   result = shift_right;
                op_or:   result = a | b;
                op_and:  result = a & b;
                default: result = sum;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== verilog/load_scoreboard.sv ====
`default_nettype none

module load_scoreboard (
    input  logic                                 clock,
    input  logic                                 reset,
    input  logic                                 issue_load,
    input  logic [rv_exec_pkg::reg_idx_bits-1:0] issue_idx,
    input  logic [rv_exec_pkg::reg_idx_bits-1:0] check_rd,
    input  logic [rv_exec_pkg::reg_idx_bits-1:0] check_rs1,
    input  logic [rv_exec_pkg::reg_idx_bits-1:0] check_rs2,
    input  logic                                 load_finish,
    input  logic [rv_exec_pkg::reg_idx_bits-1:0] finish_idx,
    output logic                                 hazard
);
    import rv_exec_pkg::*;

    // low bits only, RV32E has 16 registers
    localparam int sel_bits = $clog2(reg_count);

    logic [reg_count-1:0] pending;
    logic [reg_count-1:0] pending_next;

    always_comb begin
        pending_next = pending;
        if (load_finish)
            pending_next[finish_idx[sel_bits-1:0]] = 1'b0;
        // issue wins on the same register
        if (issue_load)
            pending_next[issue_idx[sel_bits-1:0]] = 1'b1;
    end

    always_ff @(posedge clock) begin
        if (reset)
            pending <= '0;
        else
            pending <= pending_next;
    end

    assign hazard = pending[check_rd[sel_bits-1:0]]
                  | pending[check_rs1[sel_bits-1:0]]
                  | pending[check_rs2[sel_bits-1:0]];

endmodule

`default_nettype wire

// ==== verilog/execute_unit.sv ====
`default_nettype none

module execute_unit (
    input  logic                                  clock,
    input  logic                                  reset,

    // upstream handshake and decoded fields
    input  logic                                  exe_valid,
    output logic                                  exe_ready,
    input  rv_exec_pkg::alu_op_t                  alu_op,
    input  logic                                  negate,
    input  logic                                  arith,
    input  rv_exec_pkg::src_sel_t                 src_sel,
    input  rv_exec_pkg::target_t                  target,
    input  logic                                  csr_read,
    input  logic                                  csr_write,
    input  logic                                  trap_return,
    input  rv_exec_pkg::mem_size_t                mem_size,
    input  logic                                  mem_store,
    input  logic                                  mem_signed,
    input  logic                                  rd_write,
    input  logic [rv_exec_pkg::reg_idx_bits-1:0]  rd_idx,
    input  logic [rv_exec_pkg::csr_addr_bits-1:0] csr_addr,
    input  logic [rv_exec_pkg::xlen-1:0]          pc,
    input  logic [rv_exec_pkg::xlen-1:0]          imm,
    input  logic [rv_exec_pkg::xlen-1:0]          csr_value,
    input  logic [rv_exec_pkg::xlen-1:0]          rs1,
    input  logic [rv_exec_pkg::xlen-1:0]          rs2,

    // downstream handshake and result fields
    output logic                                  out_valid,
    input  logic                                  out_ready,
    output logic                                  mem_en,
    output logic                                  mem_write,
    output logic [rv_exec_pkg::xlen-1:0]          mem_addr,
    output logic [rv_exec_pkg::xlen-1:0]          mem_wdata,
    output rv_exec_pkg::mem_size_t                mem_size_out,
    output logic                                  mem_signed_out,
    output logic [rv_exec_pkg::reg_idx_bits-1:0]  rd_idx_out,
    output logic [rv_exec_pkg::xlen-1:0]          rd_data,
    output logic                                  rd_write_out,
    output logic [rv_exec_pkg::csr_addr_bits-1:0] csr_addr_out,
    output logic [rv_exec_pkg::xlen-1:0]          csr_data,
    output logic                                  csr_write_out,
    output logic [rv_exec_pkg::xlen-1:0]          pc_out,

    // jump strobe toward fetch
    output logic                                  jump_valid,
    output logic [rv_exec_pkg::xlen-1:0]          jump_pc,

    // alu side
    output logic [rv_exec_pkg::xlen-1:0]          alu_a,
    output logic [rv_exec_pkg::xlen-1:0]          alu_b,
    output rv_exec_pkg::alu_op_t                  alu_fn,
    output logic                                  alu_negate,
    output logic                                  alu_arith,
    output logic                                  alu_seq_pc,
    input  logic [rv_exec_pkg::xlen-1:0]          alu_result,

    // scoreboard side
    input  logic                                  hazard,
    output logic                                  issue_load
);
    import rv_exec_pkg::*;

    logic accept;
    logic is_load;
    logic is_link;
    logic [xlen-1:0] tgt_a_next;
    logic [xlen-1:0] tgt_b_next;

    // registered payload
    logic [xlen-1:0]          alu_q;
    logic [xlen-1:0]          csr_old_q;
    logic [xlen-1:0]          wdata_q;
    logic [xlen-1:0]          pc_q;
    logic [xlen-1:0]          tgt_a_q;
    logic [xlen-1:0]          tgt_b_q;
    logic [reg_idx_bits-1:0]  rd_idx_q;
    logic [csr_addr_bits-1:0] csr_addr_q;
    mem_size_t                mem_size_q;
    logic                     mem_store_q;
    logic                     mem_signed_q;
    logic                     rd_write_q;
    logic                     csr_read_q;
    logic                     csr_write_q;

    // --------------------
    // handshake
    // --------------------

    // single-entry output, so no accept while it is full
    assign exe_ready = ~out_valid & ~hazard;
    assign accept = exe_valid & exe_ready;

    assign is_load = (mem_size != size_none) & ~mem_store;
    assign issue_load = accept & is_load;
    assign is_link = (target == tgt_pc_imm) | (target == tgt_rs1_imm);

    always_ff @(posedge clock) begin
        if (reset)
            out_valid <= 1'b0;
        else if (accept)
            out_valid <= 1'b1;
        else if (out_ready)
            out_valid <= 1'b0;
    end

    // one-cycle strobe, branches pulse even when not taken
    always_ff @(posedge clock) begin
        if (reset)
            jump_valid <= 1'b0;
        else
            jump_valid <= accept & (target != tgt_seq);
    end

    // --------------------
    // operands
    // --------------------

    assign alu_fn = alu_op;
    assign alu_negate = negate;
    assign alu_arith = arith;
    assign alu_seq_pc = is_link;

    always_comb begin
        case (src_sel)
            src_imm: begin
                alu_a = imm;
                alu_b = '0;
            end
            src_pc_imm: begin
                alu_a = pc;
                alu_b = imm;
            end
            src_rs1_rs2: begin
                alu_a = rs1;
                alu_b = csr_read ? csr_value : rs2;
            end
            default: begin
                alu_a = rs1;
                alu_b = imm;
            end
        endcase
        // jal/jalr write pc + 4 to rd
        if (is_link)
            alu_a = pc;
    end

    // target adder inputs, the add itself sits after the register
    always_comb begin
        case (target)
            tgt_branch: begin
                if (trap_return) begin
                    tgt_a_next = csr_value;
                    tgt_b_next = '0;
                end else begin
                    tgt_a_next = pc;
                    tgt_b_next = alu_result[0] ? imm : pc_step;
                end
            end
            tgt_seq: begin
                tgt_a_next = pc;
                tgt_b_next = pc_step;
            end
            tgt_pc_imm: begin
                tgt_a_next = pc;
                tgt_b_next = imm;
            end
            default: begin
                tgt_a_next = rs1;
                tgt_b_next = imm;
            end
        endcase
    end

    // --------------------
    // result register
    // --------------------

    always_ff @(posedge clock) begin
        if (accept) begin
            alu_q        <= alu_result;
            csr_old_q    <= csr_value;
            wdata_q      <= rs2;
            pc_q         <= pc;
            tgt_a_q      <= tgt_a_next;
            tgt_b_q      <= tgt_b_next;
            rd_idx_q     <= rd_idx;
            csr_addr_q   <= csr_addr;
            mem_size_q   <= mem_size;
            mem_store_q  <= mem_store;
            mem_signed_q <= mem_signed;
            rd_write_q   <= rd_write;
            csr_read_q   <= csr_read;
            csr_write_q  <= csr_write;
        end
    end

    assign jump_pc = tgt_a_q + tgt_b_q;

    // alu result doubles as address and new csr value
    assign mem_en         = mem_size_q != size_none;
    assign mem_write      = mem_en & mem_store_q;
    assign mem_addr       = alu_q;
    assign mem_wdata      = wdata_q;
    assign mem_size_out   = mem_size_q;
    assign mem_signed_out = mem_signed_q;

    // csr swap returns the old value to rd
    assign rd_idx_out    = rd_idx_q;
    assign rd_data       = csr_read_q ? csr_old_q : alu_q;
    assign rd_write_out  = rd_write_q;
    assign csr_addr_out  = csr_addr_q;
    assign csr_data      = alu_q;
    assign csr_write_out = csr_write_q;
    assign pc_out        = pc_q;

endmodule

`default_nettype wire

// ==== verilog/exec_top.sv ====
`default_nettype none

module exec_top (
    input  logic                                  clock,
    input  logic                                  reset,
    input  logic                                  exe_valid,
    output logic                                  exe_ready,
    input  rv_exec_pkg::alu_op_t                  alu_op,
    input  logic                                  negate,
    input  logic                                  arith,
    input  rv_exec_pkg::src_sel_t                 src_sel,
    input  rv_exec_pkg::target_t                  target,
    input  logic                                  csr_read,
    input  logic                                  csr_write,
    input  logic                                  trap_return,
    input  rv_exec_pkg::mem_size_t                mem_size,
    input  logic                                  mem_store,
    input  logic                                  mem_signed,
    input  logic                                  rd_write,
    input  logic [rv_exec_pkg::reg_idx_bits-1:0]  rd_idx,
    input  logic [rv_exec_pkg::reg_idx_bits-1:0]  rs1_idx,
    input  logic [rv_exec_pkg::reg_idx_bits-1:0]  rs2_idx,
    input  logic [rv_exec_pkg::csr_addr_bits-1:0] csr_addr,
    input  logic [rv_exec_pkg::xlen-1:0]          pc,
    input  logic [rv_exec_pkg::xlen-1:0]          imm,
    input  logic [rv_exec_pkg::xlen-1:0]          csr_value,
    input  logic [rv_exec_pkg::xlen-1:0]          rs1,
    input  logic [rv_exec_pkg::xlen-1:0]          rs2,
    output logic                                  out_valid,
    input  logic                                  out_ready,
    output logic                                  mem_en,
    output logic                                  mem_write,
    output logic [rv_exec_pkg::xlen-1:0]          mem_addr,
    output logic [rv_exec_pkg::xlen-1:0]          mem_wdata,
    output rv_exec_pkg::mem_size_t                mem_size_out,
    output logic                                  mem_signed_out,
    output logic [rv_exec_pkg::reg_idx_bits-1:0]  rd_idx_out,
    output logic [rv_exec_pkg::xlen-1:0]          rd_data,
    output logic                                  rd_write_out,
    output logic [rv_exec_pkg::csr_addr_bits-1:0] csr_addr_out,
    output logic [rv_exec_pkg::xlen-1:0]          csr_data,
    output logic                                  csr_write_out,
    output logic [rv_exec_pkg::xlen-1:0]          pc_out,
    output logic                                  jump_valid,
    output logic [rv_exec_pkg::xlen-1:0]          jump_pc,
    input  logic                                  load_finish,
    input  logic [rv_exec_pkg::reg_idx_bits-1:0]  finish_idx
);
    import rv_exec_pkg::*;

    // --------------------
    // internal nets
    // --------------------

    logic [xlen-1:0] alu_a;
    logic [xlen-1:0] alu_b;
    logic [xlen-1:0] alu_result;
    alu_op_t         alu_fn;
    logic            alu_negate;
    logic            alu_arith;
    logic            alu_seq_pc;
    logic            hazard;
    logic            issue_load;

    // port names match the top, so connect by name
    execute_unit u_execute_unit (.*);

    alu u_alu (
        .a      (alu_a),
        .b      (alu_b),
        .op     (alu_fn),
        .negate (alu_negate),
        .arith  (alu_arith),
        .seq_pc (alu_seq_pc),
        .result (alu_result)
    );

    // loads lock their rd until writeback reports them done
    load_scoreboard u_load_scoreboard (
        .clock       (clock),
        .reset       (reset),
        .issue_load  (issue_load),
        .issue_idx   (rd_idx),
        .check_rd    (rd_idx),
        .check_rs1   (rs1_idx),
        .check_rs2   (rs2_idx),
        .load_finish (load_finish),
        .finish_idx  (finish_idx),
        .hazard      (hazard)
    );

endmodule

`default_nettype wire

// ==== tests/exec_asserts.sv ====
`default_nettype none

module exec_asserts (
    input logic        clock,
    input logic        reset,
    input logic        exe_valid,
    input logic        exe_ready,
    input logic        out_valid,
    input logic        out_ready,
    input logic [31:0] rd_data,
    input logic [31:0] mem_addr,
    input logic [31:0] csr_data,
    input logic        jump_valid,
    input logic        hazard
);
    timeunit 1ns;
    timeprecision 1ps;

    // held result must not move until it is taken
    hold_stable: assert property (@(posedge clock) disable iff (reset)
        out_valid && !out_ready |=> out_valid && $stable(rd_data)
            && $stable(mem_addr) && $stable(csr_data))
        else $error("output changed while stalled");

    full_blocks_input: assert property (@(posedge clock) disable iff (reset)
        out_valid |-> !exe_ready)
        else $error("exe_ready high with a full output register");

    jump_one_cycle: assert property (@(posedge clock) disable iff (reset)
        jump_valid |=> !jump_valid)
        else $error("jump strobe longer than one cycle");

    no_accept_on_hazard: assert property (@(posedge clock) disable iff (reset)
        hazard |-> !(exe_valid && exe_ready))
        else $error("instruction accepted during a load hazard");

endmodule

bind exec_top exec_asserts exec_asserts_inst (
    .clock      (clock),
    .reset      (reset),
    .exe_valid  (exe_valid),
    .exe_ready  (exe_ready),
    .out_valid  (out_valid),
    .out_ready  (out_ready),
    .rd_data    (rd_data),
    .mem_addr   (mem_addr),
    .csr_data   (csr_data),
    .jump_valid (jump_valid),
    .hazard     (hazard)
);

`default_nettype wire

// ==== tests/exec_tb.sv ====
`default_nettype none

module exec_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import rv_exec_pkg::*;

    localparam int half_period = 20;
    localparam int max_wait = 100;

    typedef struct {
        alu_op_t     op;
        logic        neg;
        logic        ar;
        src_sel_t    src;
        target_t     tgt;
        logic        csr_rd;
        logic        csr_wr;
        logic        trap;
        mem_size_t   size;
        logic        store;
        logic        sgn;
        logic        rdw;
        logic [4:0]  rd;
        logic [4:0]  rs1_i;
        logic [4:0]  rs2_i;
        logic [11:0] caddr;
        logic [31:0] pc;
        logic [31:0] imm;
        logic [31:0] csrv;
        logic [31:0] rs1_v;
        logic [31:0] rs2_v;
        logic [31:0] exp_rd;
        logic [31:0] exp_alu;
        logic        exp_jump;
        logic [31:0] exp_jpc;
        logic        wait_load;
    } row_t;

    logic clock;
    logic reset;
    logic exe_valid;
    logic exe_ready;
    alu_op_t alu_op;
    logic negate;
    logic arith;
    src_sel_t src_sel;
    target_t target;
    logic csr_read;
    logic csr_write;
    logic trap_return;
    mem_size_t mem_size;
    logic mem_store;
    logic mem_signed;
    logic rd_write;
    logic [4:0] rd_idx;
    logic [4:0] rs1_idx;
    logic [4:0] rs2_idx;
    logic [11:0] csr_addr;
    logic [31:0] pc;
    logic [31:0] imm;
    logic [31:0] csr_value;
    logic [31:0] rs1;
    logic [31:0] rs2;
    logic out_valid;
    logic out_ready;
    logic mem_en;
    logic mem_write;
    logic [31:0] mem_addr;
    logic [31:0] mem_wdata;
    mem_size_t mem_size_out;
    logic mem_signed_out;
    logic [4:0] rd_idx_out;
    logic [31:0] rd_data;
    logic rd_write_out;
    logic [11:0] csr_addr_out;
    logic [31:0] csr_data;
    logic csr_write_out;
    logic [31:0] pc_out;
    logic jump_valid;
    logic [31:0] jump_pc;
    logic load_finish;
    logic [4:0] finish_idx;

    row_t rows[$];
    row_t r;

    exec_top exec_top_inst (.*);

    initial begin
        clock = 1'b0;
        forever #half_period clock = ~clock;
    end

    // --------------------
    // reporting
    // --------------------

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        $display("Mismatch on %s: got %h, expected %h", name, got, exp);
        $display("TESTBENCH FAILED");
        $fatal(1, "stopped on first error");
    endtask

    task automatic timeout_fail(input string what);
        $display("Timeout: %s", what);
        $display("TESTBENCH FAILED");
        $fatal(1, "stopped on timeout");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else report_mismatch(name, got, exp);
    endtask

    // --------------------
    // stimulus table
    // --------------------

    function automatic row_t base_row();
        row_t x;
        x = '{op: op_add, neg: 1'b0, ar: 1'b0, src: src_rs1_rs2, tgt: tgt_seq,
              csr_rd: 1'b0, csr_wr: 1'b0, trap: 1'b0, size: size_none,
              store: 1'b0, sgn: 1'b0, rdw: 1'b1, rd: 5'd1, rs1_i: 5'd2,
              rs2_i: 5'd3, caddr: 12'h000, pc: 32'h0000_1000, imm: 32'h0,
              csrv: 32'h0, rs1_v: 32'h0, rs2_v: 32'h0, exp_rd: 32'h0,
              exp_alu: 32'h0, exp_jump: 1'b0, exp_jpc: 32'h0, wait_load: 1'b0};
        return x;
    endfunction

    task automatic alu_row(input alu_op_t op, input logic neg, input logic ar,
                           input src_sel_t src, input logic [31:0] a_val,
                           input logic [31:0] b_val, input logic [31:0] result);
        r = base_row();
        r.op = op;
        r.neg = neg;
        r.ar = ar;
        r.src = src;
        case (src)
            src_imm: r.imm = a_val;
            src_pc_imm: begin
                r.pc = a_val;
                r.imm = b_val;
            end
            src_rs1_imm: begin
                r.rs1_v = a_val;
                r.imm = b_val;
            end
            default: begin
                r.rs1_v = a_val;
                r.rs2_v = b_val;
            end
        endcase
        r.exp_rd = result;
        r.exp_alu = result;
        rows.push_back(r);
    endtask

    task automatic build_table();
        alu_row(op_add, 0, 0, src_rs1_rs2, 32'h0000_1234, 32'h0000_0ff0, 32'h0000_2224);
        alu_row(op_add, 1, 0, src_rs1_rs2, 32'h0000_0010, 32'h0000_0020, 32'hffff_fff0);
        alu_row(op_sll, 0, 0, src_rs1_imm, 32'h0000_0003, 32'h0000_0004, 32'h0000_0030);
        alu_row(op_sll, 1, 0, src_rs1_imm, 32'h0000_0003, 32'h0000_0004, 32'h0000_0030);
        // -2 < 1 signed, but not unsigned
        alu_row(op_slt, 0, 0, src_rs1_rs2, 32'hffff_fffe, 32'h0000_0001, 32'h0000_0001);
        alu_row(op_slt, 1, 0, src_rs1_rs2, 32'hffff_fffe, 32'h0000_0001, 32'h0000_0000);
        alu_row(op_sltu, 0, 0, src_rs1_rs2, 32'hffff_fffe, 32'h0000_0001, 32'h0000_0000);
        alu_row(op_sltu, 1, 0, src_rs1_rs2, 32'hffff_fffe, 32'h0000_0001, 32'h0000_0001);
        alu_row(op_xor, 0, 0, src_rs1_rs2, 32'hf0f0_f0f0, 32'h0ff0_0ff0, 32'hff00_ff00);
        alu_row(op_xor, 1, 0, src_rs1_rs2, 32'hf0f0_f0f0, 32'h0ff0_0ff0, 32'hff00_ff00);
        alu_row(op_sr, 0, 0, src_rs1_imm, 32'h8000_0000, 32'h0000_0004, 32'h0800_0000);
        alu_row(op_sr, 1, 1, src_rs1_imm, 32'h8000_0000, 32'h0000_0004, 32'hf800_0000);
        alu_row(op_or, 0, 0, src_rs1_imm, 32'h0000_00f0, 32'h0000_0f00, 32'h0000_0ff0);
        alu_row(op_or, 1, 0, src_rs1_imm, 32'h0000_00f0, 32'h0000_0f00, 32'h0000_0ff0);
        alu_row(op_and, 0, 0, src_rs1_rs2, 32'hff00_ff00, 32'h0ff0_0ff0, 32'h0f00_0f00);
        alu_row(op_and, 1, 0, src_rs1_rs2, 32'hff00_ff00, 32'h0ff0_0ff0, 32'h0f00_0f00);
        alu_row(op_add, 0, 0, src_imm, 32'h1234_5000, 32'h0000_0000, 32'h1234_5000);
        alu_row(op_add, 0, 0, src_pc_imm, 32'h0000_1000, 32'h0000_0800, 32'h0000_1800);

        // blt taken, then bge on the same operands falls through
        r = base_row();
        r.op = op_slt;
        r.tgt = tgt_branch;
        r.rdw = 1'b0;
        r.pc = 32'h0000_0100;
        r.imm = 32'h0000_0040;
        r.rs1_v = 32'hffff_ffff;
        r.rs2_v = 32'h0000_0002;
        r.exp_rd = 32'h1;
        r.exp_alu = 32'h1;
        r.exp_jump = 1'b1;
        r.exp_jpc = 32'h0000_0140;
        rows.push_back(r);
        r.neg = 1'b1;
        r.exp_rd = 32'h0;
        r.exp_alu = 32'h0;
        r.exp_jpc = 32'h0000_0104;
        rows.push_back(r);

        // jal and jalr link pc + 4
        r = base_row();
        r.src = src_pc_imm;
        r.tgt = tgt_pc_imm;
        r.pc = 32'h0000_0200;
        r.imm = 32'h0000_0080;
        r.exp_rd = 32'h0000_0204;
        r.exp_alu = 32'h0000_0204;
        r.exp_jump = 1'b1;
        r.exp_jpc = 32'h0000_0280;
        rows.push_back(r);
        r.src = src_rs1_imm;
        r.tgt = tgt_rs1_imm;
        r.pc = 32'h0000_0300;
        r.rs1_v = 32'h0000_3001;
        r.imm = 32'h0000_0010;
        r.exp_rd = 32'h0000_0304;
        r.exp_alu = 32'h0000_0304;
        r.exp_jpc = 32'h0000_3011;
        rows.push_back(r);

        // trap return jumps to the csr value
        r = base_row();
        r.src = src_imm;
        r.tgt = tgt_branch;
        r.trap = 1'b1;
        r.rdw = 1'b0;
        r.csrv = 32'h8000_0100;
        r.exp_jump = 1'b1;
        r.exp_jpc = 32'h8000_0100;
        rows.push_back(r);

        // store word
        r = base_row();
        r.src = src_rs1_imm;
        r.size = size_word;
        r.store = 1'b1;
        r.rdw = 1'b0;
        r.rs1_v = 32'h0000_1000;
        r.imm = 32'h0000_0008;
        r.rs2_v = 32'hdead_beef;
        r.exp_rd = 32'h0000_1008;
        r.exp_alu = 32'h0000_1008;
        rows.push_back(r);

        // signed half load to x5, then a reader of x5 that must stall
        r = base_row();
        r.src = src_rs1_imm;
        r.size = size_half;
        r.sgn = 1'b1;
        r.rd = 5'd5;
        r.rs1_v = 32'h0000_2000;
        r.imm = 32'hffff_fffe;
        r.exp_rd = 32'h0000_1ffe;
        r.exp_alu = 32'h0000_1ffe;
        rows.push_back(r);
        alu_row(op_add, 0, 0, src_rs1_rs2, 32'h0000_0005, 32'h0000_0006, 32'h0000_000b);
        rows[rows.size()-1].rs1_i = 5'd5;
        rows[rows.size()-1].wait_load = 1'b1;

        // csr swap writes rs1 or csr and returns the old value to rd
        r = base_row();
        r.op = op_or;
        r.csr_rd = 1'b1;
        r.csr_wr = 1'b1;
        r.caddr = 12'h300;
        r.rs1_v = 32'h0000_0008;
        r.csrv = 32'h0000_1800;
        r.exp_rd = 32'h0000_1800;
        r.exp_alu = 32'h0000_1808;
        rows.push_back(r);
    endtask

    // --------------------
    // driver and checks
    // --------------------

    task automatic drive_row(input row_t x);
        alu_op = x.op;
        negate = x.neg;
        arith = x.ar;
        src_sel = x.src;
        target = x.tgt;
        csr_read = x.csr_rd;
        csr_write = x.csr_wr;
        trap_return = x.trap;
        mem_size = x.size;
        mem_store = x.store;
        mem_signed = x.sgn;
        rd_write = x.rdw;
        rd_idx = x.rd;
        rs1_idx = x.rs1_i;
        rs2_idx = x.rs2_i;
        csr_addr = x.caddr;
        pc = x.pc;
        imm = x.imm;
        csr_value = x.csrv;
        rs1 = x.rs1_v;
        rs2 = x.rs2_v;
        exe_valid = 1'b1;
    endtask

    task automatic wait_accept();
        int n;
        n = 0;
        #1;
        while (!exe_ready) begin
            n++;
            if (n > max_wait)
                timeout_fail("instruction was never accepted");
            @(negedge clock);
            #1;
        end
        @(posedge clock);
        @(negedge clock);
        exe_valid = 1'b0;
    endtask

    task automatic wait_transfer();
        int n;
        logic taken;
        n = 0;
        taken = 1'b0;
        while (!taken) begin
            // random back-pressure from the writeback side
            out_ready = ($urandom % 3) != 0;
            #1;
            if (out_valid && out_ready) begin
                taken = 1'b1;
            end else begin
                n++;
                if (n > max_wait)
                    timeout_fail("result never left the output register");
                @(negedge clock);
            end
        end
    endtask

    task automatic check_outputs(input row_t x);
        logic exp_en;
        exp_en = x.size != size_none;
        check_value("rd_data", rd_data, x.exp_rd);
        check_value("mem_addr", mem_addr, x.exp_alu);
        check_value("csr_data", csr_data, x.exp_alu);
        check_value("mem_en", {31'b0, mem_en}, {31'b0, exp_en});
        check_value("mem_write", {31'b0, mem_write}, {31'b0, exp_en & x.store});
        check_value("mem_wdata", mem_wdata, x.rs2_v);
        check_value("mem_size_out", {30'b0, mem_size_out}, {30'b0, x.size});
        check_value("mem_signed_out", {31'b0, mem_signed_out}, {31'b0, x.sgn});
        check_value("rd_idx_out", {27'b0, rd_idx_out}, {27'b0, x.rd});
        check_value("rd_write_out", {31'b0, rd_write_out}, {31'b0, x.rdw});
        check_value("csr_addr_out", {20'b0, csr_addr_out}, {20'b0, x.caddr});
        check_value("csr_write_out", {31'b0, csr_write_out}, {31'b0, x.csr_wr});
        check_value("pc_out", pc_out, x.pc);
    endtask

    initial begin
        row_t x;
        void'($urandom(32'hce8e));
        reset = 1'b1;
        drive_row(base_row());
        exe_valid = 1'b0;
        out_ready = 1'b0;
        load_finish = 1'b0;
        finish_idx = 5'd0;
        build_table();
        repeat (4) @(negedge clock);
        reset = 1'b0;
        #1;
        check_value("exe_ready", {31'b0, exe_ready}, 32'h1);
        check_value("out_valid", {31'b0, out_valid}, 32'h0);
        check_value("jump_valid", {31'b0, jump_valid}, 32'h0);
        @(negedge clock);

        foreach (rows[i]) begin
            x = rows[i];
            drive_row(x);
            if (x.wait_load) begin
                repeat (3) begin
                    #1;
                    check_value("exe_ready", {31'b0, exe_ready}, 32'h0);
                    @(negedge clock);
                end
                load_finish = 1'b1;
                finish_idx = x.rs1_i;
                @(negedge clock);
                load_finish = 1'b0;
            end
            wait_accept();
            check_value("jump_valid", {31'b0, jump_valid}, {31'b0, x.exp_jump});
            if (x.exp_jump)
                check_value("jump_pc", jump_pc, x.exp_jpc);
            wait_transfer();
            check_outputs(x);
            @(negedge clock);
            out_ready = 1'b0;
        end

        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== list.f ====
verilog/rv_exec_pkg.sv
verilog/alu.sv
verilog/load_scoreboard.sv
verilog/execute_unit.sv
verilog/exec_top.sv
tests/exec_asserts.sv
tests/exec_tb.sv

// ==== Makefile ====
# Verilator build and run for the execute stage testbench

VERILATOR ?= verilator
TOP       ?= exec_tb
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FILE_LIST ?= list.f
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SOURCES := $(shell grep -v '^+' $(FILE_LIST))
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILE_LIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILE_LIST)

run: $(BIN)
	-./$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TESTBENCH FAILED" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi
	@if ! grep -q "TESTBENCH PASSED" $(LOG); then \
		echo "simulation ended without a result, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
